// ==== rtl/dphy_rx_consts.svh ====
`ifndef DPHY_RX_CONSTS_SVH
`define DPHY_RX_CONSTS_SVH

// Settle window and byte clock period, both in picoseconds
`define DPHY_T_SETTLE_PS 150000
`define DPHY_T_CLK_PS    5000

// Sync pattern 00011101 on the wire, earliest bit in bit 0
`define DPHY_SYNC_BYTE   8'hB8

`define DPHY_FIFO_DEPTH  16

// APB register offsets
`define DPHY_ADDR_STATUS 32'h0000_0000
`define DPHY_ADDR_DATA   32'h0000_0004
`define DPHY_ADDR_BURSTS 32'h0000_0008

`endif

// ==== rtl/dphy_rx_pkg.sv ====
package dphy_rx_pkg;

  // D-PHY line states seen by the settle detector
  typedef enum logic [2:0] {
    IDLE,
    LP_11,
    LP_01,
    LP_00,
    HS
  } lp_state_e;

  typedef enum logic [1:0] {
    HUNT,
    LOCKED
  } align_state_e;

  // First flag lands in bit 8 when read over APB
  typedef struct packed {
    logic       first;
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic [7:0] level;
    logic [4:0] rsvd;
    logic       settle_active;
    logic       overflow;
    logic       empty;
  } rx_status_t;

endpackage

// ==== rtl/dphy_settle_ignore.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_settle_ignore #(
  parameter int T_SETTLE = `DPHY_T_SETTLE_PS,
  parameter int T_CLK    = `DPHY_T_CLK_PS
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic lp_data_p_i,
  input  logic lp_data_n_i,
  output logic hs_data_valid_o,
  output logic settle_active_o
);

  localparam int IGNORE_TICKS = T_SETTLE / T_CLK;
  localparam int CNT_W        = $clog2(IGNORE_TICKS + 1);

  dphy_rx_pkg::lp_state_e state;
  dphy_rx_pkg::lp_state_e next_state;
  logic [CNT_W-1:0]       ignore_cnt;
  logic [1:0]             lp_p_sync;
  logic [1:0]             lp_n_sync;
  logic                   lp_p;
  logic                   lp_n;

  // Two-flop synchronizer on each LP pin
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      lp_p_sync <= '0;
      lp_n_sync <= '0;
    end
    else
    begin
      lp_p_sync <= {lp_p_sync[0], lp_data_p_i};
      lp_n_sync <= {lp_n_sync[0], lp_data_n_i};
    end

  assign lp_p = lp_p_sync[1];
  assign lp_n = lp_n_sync[1];

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      state <= dphy_rx_pkg::IDLE;
    else
      state <= next_state;

  // Walks the start-of-transmission sequence, one state per clock
  always_comb
  begin
    next_state = state;
    case (state)
      dphy_rx_pkg::IDLE:
        if (lp_p && lp_n)
          next_state = dphy_rx_pkg::LP_11;
      dphy_rx_pkg::LP_11:
        if (!lp_p && lp_n)
          next_state = dphy_rx_pkg::LP_01;
      dphy_rx_pkg::LP_01:
        if (!lp_p && !lp_n)
          next_state = dphy_rx_pkg::LP_00;
      dphy_rx_pkg::LP_00:
        if (ignore_cnt == CNT_W'(IGNORE_TICKS))
          next_state = dphy_rx_pkg::HS;
      dphy_rx_pkg::HS:
        if (lp_p && lp_n)
          next_state = dphy_rx_pkg::LP_11;
      default:
        next_state = dphy_rx_pkg::IDLE;
    endcase
  end

  // Settle window, HS lines are still unreliable here
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      ignore_cnt <= '0;
    else if (state == dphy_rx_pkg::LP_00)
      ignore_cnt <= ignore_cnt + 1'b1;
    else
      ignore_cnt <= '0;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      hs_data_valid_o <= 1'b0;
    else
      hs_data_valid_o <= (state == dphy_rx_pkg::HS);

  assign settle_active_o = (state == dphy_rx_pkg::LP_00);

endmodule

// ==== rtl/dphy_hs_aligner.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_hs_aligner (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  hs_valid_i,
  input  logic [7:0]            hs_byte_i,
  output dphy_rx_pkg::rx_byte_t byte_o,
  output logic                  byte_valid_o
);

  dphy_rx_pkg::align_state_e state;
  logic [7:0]                prev_byte;
  logic [15:0]               window;
  logic                      hit;
  logic [2:0]                hit_off;
  logic [2:0]                lock_off;
  logic                      first_pend;

  // Older byte in the low half, so bit order follows the wire
  assign window = {hs_byte_i, prev_byte};

  // Zeroed outside HS, which looks like the HS-zero preamble
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      prev_byte <= '0;
    else if (hs_valid_i)
      prev_byte <= hs_byte_i;
    else
      prev_byte <= '0;

  // Scan from the top so the lowest matching offset wins
  always_comb
  begin
    hit     = 1'b0;
    hit_off = '0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == `DPHY_SYNC_BYTE)
      begin
        hit     = 1'b1;
        hit_off = 3'(i);
      end
    end
  end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      state      <= dphy_rx_pkg::HUNT;
      lock_off   <= '0;
      first_pend <= 1'b0;
    end
    else if (!hs_valid_i)
    begin
      state      <= dphy_rx_pkg::HUNT;
      first_pend <= 1'b0;
    end
    else if (state == dphy_rx_pkg::HUNT && hit)
    begin
      state      <= dphy_rx_pkg::LOCKED;
      lock_off   <= hit_off;
      first_pend <= 1'b1;
    end
    else if (state == dphy_rx_pkg::LOCKED)
      first_pend <= 1'b0;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      byte_valid_o <= 1'b0;
    else
      byte_valid_o <= hs_valid_i && (state == dphy_rx_pkg::LOCKED);

  always_ff @(posedge clk_i)
  begin
    byte_o.data  <= window[lock_off +: 8];
    byte_o.first <= first_pend;
  end

endmodule

// ==== rtl/dphy_lane_rx.sv ====
`timescale 1ns/1ps

module dphy_lane_rx (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  lp_data_p_i,
  input  logic                  lp_data_n_i,
  input  logic [7:0]            hs_byte_i,
  input  logic                  burst_clr_i,
  output dphy_rx_pkg::rx_byte_t byte_o,
  output logic                  byte_valid_o,
  output logic                  settle_active_o,
  output logic [15:0]           bursts_o
);

  logic hs_valid;

  dphy_settle_ignore settle_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lp_data_p_i     (lp_data_p_i),
    .lp_data_n_i     (lp_data_n_i),
    .hs_data_valid_o (hs_valid),
    .settle_active_o (settle_active_o)
  );

  // Aligner only sees bytes once the settle window has passed
  dphy_hs_aligner align_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hs_valid_i   (hs_valid),
    .hs_byte_i    (hs_byte_i),
    .byte_o       (byte_o),
    .byte_valid_o (byte_valid_o)
  );

  // One first-flagged byte per lock, so one count per burst
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      bursts_o <= '0;
    else if (burst_clr_i)
      bursts_o <= '0;
    else if (byte_valid_o && byte_o.first)
      bursts_o <= bursts_o + 1'b1;

endmodule

// ==== rtl/dphy_byte_fifo.sv ====
`timescale 1ns/1ps

module dphy_byte_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         wr_i,
  input  dphy_rx_pkg::rx_byte_t        wr_data_i,
  input  logic                         rd_i,
  input  logic                         ovf_clr_i,
  output dphy_rx_pkg::rx_byte_t        rd_data_o,
  output logic [$clog2(DEPTH+1)-1:0]   level_o,
  output logic                         empty_o,
  output logic                         overflow_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int LW = $clog2(DEPTH + 1);

  dphy_rx_pkg::rx_byte_t mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic                  full;
  logic                  do_wr;
  logic                  do_rd;

  assign full    = (level_o == LW'(DEPTH));
  assign empty_o = (level_o == '0);
  assign do_wr   = wr_i && !full;
  assign do_rd   = rd_i && !empty_o;

  always_ff @(posedge clk_i)
    if (do_wr)
      mem[wr_ptr] <= wr_data_i;

  // Head entry is visible without a read request
  assign rd_data_o = mem[rd_ptr];

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_o <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   level_o <= level_o + 1'b1;
        2'b01:   level_o <= level_o - 1'b1;
        default: level_o <= level_o;
      endcase
    end

  // Sticky until cleared, a new drop wins over the clear
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      overflow_o <= 1'b0;
    else if (wr_i && full)
      overflow_o <= 1'b1;
    else if (ovf_clr_i)
      overflow_o <= 1'b0;

endmodule

// ==== rtl/dphy_apb_reader.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_apb_reader #(
  parameter int LVL_W = 5
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [31:0]           paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  dphy_rx_pkg::rx_byte_t fifo_data_i,
  input  logic [LVL_W-1:0]      fifo_level_i,
  input  logic                  fifo_empty_i,
  input  logic                  fifo_ovf_i,
  input  logic                  settle_active_i,
  input  logic [15:0]           bursts_i,
  output logic                  pop_o,
  output logic                  clear_o
);

  dphy_rx_pkg::rx_status_t status;
  logic                    rd_access;
  logic                    wr_access;
  logic                    sel_status;
  logic                    sel_data;
  logic                    sel_bursts;

  // Only the access phase does anything
  assign rd_access  = psel_i && penable_i && !pwrite_i;
  assign wr_access  = psel_i && penable_i && pwrite_i;
  assign sel_status = (paddr_i == `DPHY_ADDR_STATUS);
  assign sel_data   = (paddr_i == `DPHY_ADDR_DATA);
  assign sel_bursts = (paddr_i == `DPHY_ADDR_BURSTS);

  always_comb
  begin
    status               = '0;
    status.level         = 8'(fifo_level_i);
    status.settle_active = settle_active_i;
    status.overflow      = fifo_ovf_i;
    status.empty         = fifo_empty_i;
  end

  // Read data is combinational, no wait states
  always_comb
  begin
    prdata_o = '0;
    if (sel_status)
      prdata_o = 32'(status);
    else if (sel_data && !fifo_empty_i)
      prdata_o = 32'(fifo_data_i);
    else if (sel_bursts)
      prdata_o = 32'(bursts_i);
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = rd_access && sel_data && fifo_empty_i;
  assign pop_o     = rd_access && sel_data && !fifo_empty_i;

  // Clear pulse for overflow and burst count
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      clear_o <= 1'b0;
    else
      clear_o <= wr_access && sel_status && pwdata_i[0];

endmodule

// ==== rtl/dphy_rx_top.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_rx_top (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        lp_data_p_i,
  input  logic        lp_data_n_i,
  input  logic [7:0]  hs_byte_i,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  localparam int LVL_W = $clog2(`DPHY_FIFO_DEPTH + 1);

  dphy_rx_pkg::rx_byte_t rx_byte;
  dphy_rx_pkg::rx_byte_t fifo_head;
  logic                  rx_valid;
  logic                  settle_active;
  logic [15:0]           bursts;
  logic [LVL_W-1:0]      fifo_level;
  logic                  fifo_empty;
  logic                  fifo_ovf;
  logic                  pop;
  logic                  clear;

  dphy_lane_rx lane_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lp_data_p_i     (lp_data_p_i),
    .lp_data_n_i     (lp_data_n_i),
    .hs_byte_i       (hs_byte_i),
    .burst_clr_i     (clear),
    .byte_o          (rx_byte),
    .byte_valid_o    (rx_valid),
    .settle_active_o (settle_active),
    .bursts_o        (bursts)
  );

  dphy_byte_fifo #(
    .DEPTH (`DPHY_FIFO_DEPTH)
  ) fifo_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_i       (rx_valid),
    .wr_data_i  (rx_byte),
    .rd_i       (pop),
    .ovf_clr_i  (clear),
    .rd_data_o  (fifo_head),
    .level_o    (fifo_level),
    .empty_o    (fifo_empty),
    .overflow_o (fifo_ovf)
  );

  dphy_apb_reader #(
    .LVL_W (LVL_W)
  ) apb_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .paddr_i         (paddr_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .fifo_data_i     (fifo_head),
    .fifo_level_i    (fifo_level),
    .fifo_empty_i    (fifo_empty),
    .fifo_ovf_i      (fifo_ovf),
    .settle_active_i (settle_active),
    .bursts_i        (bursts),
    .pop_o           (pop),
    .clear_o         (clear)
  );

endmodule

// ==== verification/dphy_rx_asserts.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_rx_asserts #(
  parameter int DEPTH = `DPHY_FIFO_DEPTH
) (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pready_i,
  input logic                       pslverr_i,
  input logic [$clog2(DEPTH+1)-1:0] fifo_level_i
);

  // Read by the testbench at the end of the run
  int fail_cnt = 0;

  // No wait states on this slave
  pready_high: assert property (@(posedge clk_i) disable iff (rst_i) pready_i)
    else
    begin
      $error("pready_o went low");
      fail_cnt++;
    end

  pslverr_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
    pslverr_i |-> (psel_i && penable_i))
    else
    begin
      $error("pslverr_o high outside an access phase");
      fail_cnt++;
    end

  level_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    fifo_level_i <= DEPTH)
    else
    begin
      $error("FIFO level above its depth");
      fail_cnt++;
    end

endmodule

bind dphy_rx_top dphy_rx_asserts asserts_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pready_i     (pready_o),
  .pslverr_i    (pslverr_o),
  .fifo_level_i (fifo_level)
);

// ==== verification/dphy_rx_tb.sv ====
`timescale 1ns/1ps
`include "dphy_rx_consts.svh"

module dphy_rx_tb;

  localparam int         SETTLE_TICKS = `DPHY_T_SETTLE_PS / `DPHY_T_CLK_PS;
  localparam int         GARBAGE_CYC  = SETTLE_TICKS / 2;
  localparam int         DEPTH        = `DPHY_FIFO_DEPTH;
  localparam int         NUM_BURSTS   = 9;
  localparam int         MAX_LEN      = 32;
  localparam logic [7:0] SYNC         = `DPHY_SYNC_BYTE;

  typedef struct packed {
    logic [79:0] name;
    logic [2:0]  offset;
    logic [7:0]  len;
    logic        garbage;
  } burst_t;

  // Name, sync bit offset, payload length, garbage during LP-00
  localparam burst_t BURSTS [NUM_BURSTS] = '{
    '{"off0",      3'd0, 8'd5,  1'b0},
    '{"off3",      3'd3, 8'd6,  1'b0},
    '{"off5_garb", 3'd5, 8'd4,  1'b1},
    '{"off7",      3'd7, 8'd8,  1'b0},
    '{"off1_garb", 3'd1, 8'd3,  1'b1},
    '{"off2",      3'd2, 8'd7,  1'b0},
    '{"overflow",  3'd4, 8'd20, 1'b0},
    '{"off6",      3'd6, 8'd3,  1'b0},
    '{"off4_garb", 3'd4, 8'd5,  1'b1}
  };

  logic        clk;
  logic        rst;
  logic        lp_p;
  logic        lp_n;
  logic [7:0]  hs_byte;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] lcg_state;
  logic [7:0]  payload [MAX_LEN];
  string       cur_name;
  int          test_errs;
  int          total_errs;
  int          tests_passed;
  int          tests_failed;
  int          bursts_exp;
  int          cycle_cnt;
  int          cycle_limit;

  dphy_rx_top dut_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .lp_data_p_i (lp_p),
    .lp_data_n_i (lp_n),
    .hs_byte_i   (hs_byte),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr)
  );

  always #20 clk = ~clk;

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Level in bits 15:8, overflow in bit 1, empty in bit 0
  function automatic logic [31:0] status_word(input int level, input logic ovf);
    return {16'h0, 8'(level), 6'b0, ovf, (level == 0)};
  endfunction

  // Sequencing overhead per burst plus the APB reads, doubled for margin
  function automatic int limit_cycles();
    int sum;
    int t;
    sum = 100;
    for (t = 0; t < NUM_BURSTS; t++)
      sum += 30 + SETTLE_TICKS + int'(BURSTS[t].len) + 4 * (int'(BURSTS[t].len) + 8);
    return 2 * sum;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("error: test %0s, %0s expected %08h, actual %08h", cur_name, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    // Read data is valid within the access phase
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_val("PREADY", 32'h1, 32'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // LP-11, LP-01, LP-00, then the HS stream once the settle window ends
  task automatic send_burst(input burst_t b);
    logic [511:0] bits;
    logic [31:0]  data;
    logic         err;
    int           len;
    int           pos;
    int           i;
    int           k;
    len  = int'(b.len);
    pos  = int'(b.offset);
    bits = '0;
    for (i = 0; i < len; i++)
      payload[i] = lcg_next();
    bits[pos +: 8] = SYNC;
    for (i = 0; i < len; i++)
      bits[pos + 8 + 8 * i +: 8] = payload[i];
    @(posedge clk);
    lp_p    <= 1'b1;
    lp_n    <= 1'b1;
    hs_byte <= 8'h00;
    repeat (4) @(posedge clk);
    lp_p <= 1'b0;
    repeat (4) @(posedge clk);
    lp_n <= 1'b0;
    for (k = 0; k < GARBAGE_CYC; k++)
    begin
      @(posedge clk);
      if (b.garbage)
        hs_byte <= k[0] ? SYNC : lcg_next();
    end
    @(posedge clk);
    hs_byte <= 8'h00;
    // Settle flag shows in STATUS while LP-00 is still masked
    apb_read(`DPHY_ADDR_STATUS, data, err);
    check_val("STATUS in settle", status_word(0, 1'b0) | 32'h4, data);
    @(negedge clk);
    while (!dut_i.lane_i.hs_valid)
      @(negedge clk);
    // LP-11 returns early so that the last lane byte out is the last payload byte
    for (k = 0; k < len + 2; k++)
    begin
      @(posedge clk);
      hs_byte <= bits[8 * k +: 8];
      if (k == len - 2)
      begin
        lp_p <= 1'b1;
        lp_n <= 1'b1;
      end
    end
    @(posedge clk);
    hs_byte <= 8'h00;
    repeat (6) @(posedge clk);
  endtask

  task automatic end_test();
    if (test_errs == 0)
    begin
      $display("test %0s: passed", cur_name);
      tests_passed++;
    end
    else
    begin
      $display("test %0s: failed with %0d errors", cur_name, test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
  endtask

  task automatic run_burst_test(input burst_t b);
    logic [31:0] data;
    logic        err;
    int          len;
    int          stored;
    int          j;
    cur_name  = $sformatf("%0s", b.name);
    test_errs = 0;
    len       = int'(b.len);
    stored    = (len > DEPTH) ? DEPTH : len;
    send_burst(b);
    bursts_exp++;
    apb_read(`DPHY_ADDR_STATUS, data, err);
    check_val("STATUS after burst", status_word(stored, len > DEPTH), data);
    apb_read(`DPHY_ADDR_BURSTS, data, err);
    check_val("BURSTS", 32'(bursts_exp), data);
    for (j = 0; j < stored; j++)
    begin
      apb_read(`DPHY_ADDR_DATA, data, err);
      check_val($sformatf("DATA[%0d]", j), {23'h0, (j == 0), payload[j]}, data);
      check_val($sformatf("PSLVERR[%0d]", j), 32'h0, 32'(err));
    end
    apb_read(`DPHY_ADDR_STATUS, data, err);
    check_val("STATUS after drain", status_word(0, len > DEPTH), data);
    if (len > DEPTH)
    begin
      apb_write(`DPHY_ADDR_STATUS, 32'h1);
      bursts_exp = 0;
      apb_read(`DPHY_ADDR_STATUS, data, err);
      check_val("STATUS after clear", status_word(0, 1'b0), data);
      apb_read(`DPHY_ADDR_BURSTS, data, err);
      check_val("BURSTS after clear", 32'h0, data);
    end
    end_test();
  endtask

  initial
  begin
    @(posedge clk);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    logic [31:0] data;
    logic        err;
    int          t;
    clk          = 1'b0;
    rst          = 1'b1;
    lp_p         = 1'b1;
    lp_n         = 1'b1;
    hs_byte      = 8'h00;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    lcg_state    = 32'd60838;
    total_errs   = 0;
    tests_passed = 0;
    tests_failed = 0;
    bursts_exp   = 0;
    cycle_cnt    = 0;
    cycle_limit  = limit_cycles();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    cur_name  = "reset";
    test_errs = 0;
    apb_read(`DPHY_ADDR_STATUS, data, err);
    check_val("STATUS", status_word(0, 1'b0), data);
    apb_read(`DPHY_ADDR_BURSTS, data, err);
    check_val("BURSTS", 32'h0, data);
    end_test();

    cur_name  = "empty_read";
    test_errs = 0;
    apb_read(`DPHY_ADDR_DATA, data, err);
    check_val("DATA", 32'h0, data);
    check_val("PSLVERR", 32'h1, 32'(err));
    apb_read(`DPHY_ADDR_STATUS, data, err);
    check_val("STATUS", status_word(0, 1'b0), data);
    end_test();

    for (t = 0; t < NUM_BURSTS; t++)
      run_burst_test(BURSTS[t]);

    $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
             tests_passed + tests_failed, tests_passed, tests_failed,
             dut_i.asserts_i.fail_cnt);
    if (total_errs == 0 && dut_i.asserts_i.fail_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/dphy_rx_pkg.sv
rtl/dphy_settle_ignore.sv
rtl/dphy_hs_aligner.sv
rtl/dphy_lane_rx.sv
rtl/dphy_byte_fifo.sv
rtl/dphy_apb_reader.sv
rtl/dphy_rx_top.sv
verification/dphy_rx_asserts.sv
verification/dphy_rx_tb.sv

// ==== Makefile ====
# Verilator build for the D-PHY lane receiver testbench
VERILATOR ?= verilator
TOP       ?= dphy_rx_tb
SRC_LIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(SRC_LIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SRC_LIST)
	-$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL: no result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
